/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_core_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "simulation result: FAIL"; exit 1; \
	else \
	  echo "simulation result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bridge_decode.sv */
////////////////////////////////////////////////////////////
// bridge write decoder
// settings register block, reset request, download pushes
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module bridge_decode (
  input  logic                     clk_74a,
  input  logic                     arst_n,
  input  core_pkg::bridge_addr_t   bridge_addr,
  input  logic                     bridge_wr,
  input  core_pkg::bridge_data_t   bridge_wr_data,
  output core_pkg::core_settings_t settings,
  output logic                     reset_hold_start,
  output logic                     load_push,
  output core_pkg::load_word_t     load_word
);

  logic in_load_region;

  assign in_load_region = (bridge_addr[31:28] == core_pkg::LOAD_REGION);

  // combinational so the hold timer can raise core_reset one cycle later
  assign reset_hold_start = bridge_wr && (bridge_addr == core_pkg::ADDR_RESET);

  ////////////////////////////////////////////////////////////
  // settings block
  ////////////////////////////////////////////////////////////

  // full address match and only the field's low bits taken
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        core_pkg::ADDR_TURBO_TAP:
          settings.turbo_tap_enable <= bridge_wr_data[0];
        core_pkg::ADDR_BUTTON6:
          settings.button6_enable <= bridge_wr_data[0];
        core_pkg::ADDR_BTN1_SPEED:
          settings.button1_turbo_speed <= bridge_wr_data[1:0];
        core_pkg::ADDR_BTN2_SPEED:
          settings.button2_turbo_speed <= bridge_wr_data[1:0];
        core_pkg::ADDR_OVERSCAN:
          settings.overscan_enable <= bridge_wr_data[0];
        core_pkg::ADDR_EXTRA_SPRITES:
          settings.extra_sprites_enable <= bridge_wr_data[0];
        core_pkg::ADDR_RAW_RGB:
          settings.raw_rgb_enable <= bridge_wr_data[0];
        core_pkg::ADDR_MASTER_BOOST:
          settings.master_audio_boost <= bridge_wr_data[1:0];
        core_pkg::ADDR_ADPCM_BOOST:
          settings.adpcm_audio_boost <= bridge_wr_data[0];
        core_pkg::ADDR_CD_BOOST:
          settings.cd_audio_boost <= bridge_wr_data[0];
        default: begin
          // unmapped address changes nothing
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // download path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      load_push <= 1'b0;
    end else begin
      load_push <= bridge_wr && in_load_region;
    end
  end

  // big-endian word kept as is and split later
  always_ff @(posedge clk_74a) begin
    if (bridge_wr && in_load_region) begin
      load_word.addr <= bridge_addr[23:0];
      load_word.data <= bridge_wr_data;
    end
  end

endmodule

/* build.f */
core_pkg.sv
bridge_decode.sv
reset_hold_timer.sv
load_word_fifo.sv
pace_timer.sv
loader_sequencer.sv
core_top.sv
core_top_asserts.sv
tb_core_top.sv

/* core_pkg.sv */
////////////////////////////////////////////////////////////
// shared types and constants for the bridge control logic
// bridge and memory widths, setting addresses, timing,
// packed settings and loader structs, loader FSM states
////////////////////////////////////////////////////////////

package core_pkg;

  // bus widths
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [23:0] mem_addr_t;
  typedef logic [15:0] mem_half_t;
  typedef logic [1:0]  boost_t;

  ////////////////////////////////////////////////////////////
  // bridge register map
  ////////////////////////////////////////////////////////////

  localparam bridge_addr_t ADDR_RESET         = 32'h0000_0050;
  localparam bridge_addr_t ADDR_TURBO_TAP     = 32'h0000_0100;
  localparam bridge_addr_t ADDR_BUTTON6       = 32'h0000_0104;
  localparam bridge_addr_t ADDR_BTN1_SPEED    = 32'h0000_0108;
  localparam bridge_addr_t ADDR_BTN2_SPEED    = 32'h0000_010C;
  localparam bridge_addr_t ADDR_OVERSCAN      = 32'h0000_0200;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h0000_0204;
  localparam bridge_addr_t ADDR_RAW_RGB       = 32'h0000_0208;
  localparam bridge_addr_t ADDR_MASTER_BOOST  = 32'h0000_0300;
  localparam bridge_addr_t ADDR_ADPCM_BOOST   = 32'h0000_0304;
  localparam bridge_addr_t ADDR_CD_BOOST      = 32'h0000_0308;

  // upper address nibble of the cart download window
  localparam logic [3:0] LOAD_REGION = 4'h1;

  ////////////////////////////////////////////////////////////
  // timing and sizes
  ////////////////////////////////////////////////////////////

  localparam int RESET_HOLD_CYCLES = 256;
  localparam int WRITE_SLOT_CYCLES = 16;
  localparam int WRITE_EN_CYCLES   = 8;
  localparam int LOAD_FIFO_DEPTH   = 8;

  localparam int FIFO_IDX_W = $clog2(LOAD_FIFO_DEPTH);

  // counter widths
  typedef logic [$clog2(RESET_HOLD_CYCLES + 1)-1:0] hold_cnt_t;
  typedef logic [$clog2(WRITE_SLOT_CYCLES)-1:0]     slot_cnt_t;
  // one extra wrap bit on top of the index
  typedef logic [FIFO_IDX_W:0]                      fifo_ptr_t;

  localparam slot_cnt_t SLOT_LAST   = slot_cnt_t'(WRITE_SLOT_CYCLES - 1);
  localparam slot_cnt_t SLOT_EN_END = slot_cnt_t'(WRITE_EN_CYCLES);

  ////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   turbo_tap_enable;
    logic   button6_enable;
    boost_t button1_turbo_speed;
    boost_t button2_turbo_speed;
    logic   overscan_enable;
    logic   extra_sprites_enable;
    logic   raw_rgb_enable;
    boost_t master_audio_boost;
    logic   adpcm_audio_boost;
    logic   cd_audio_boost;
  } core_settings_t;

  typedef struct packed {
    mem_addr_t    addr;
    bridge_data_t data;
  } load_word_t;

  typedef struct packed {
    logic      en;
    mem_addr_t addr;
    mem_half_t data;
  } mem_write_t;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_HI,
    LOAD_LO
  } loader_state_t;

endpackage

/* core_top.sv */
////////////////////////////////////////////////////////////
// bridge control top level
// decode, reset hold, download FIFO, loader and pacing
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module core_top (
  input  logic                     clk_74a,
  input  logic                     arst_n,
  input  core_pkg::bridge_addr_t   bridge_addr,
  input  logic                     bridge_wr,
  input  core_pkg::bridge_data_t   bridge_wr_data,
  output core_pkg::core_settings_t settings,
  output logic                     core_reset,
  output core_pkg::mem_write_t     load_write,
  output logic                     load_overflow
);

  logic                 reset_hold_start;
  logic                 load_push;
  core_pkg::load_word_t load_word;
  logic                 fifo_empty;
  core_pkg::load_word_t fifo_word;
  logic                 fifo_pop;
  logic                 slot_start;
  logic                 slot_en;
  logic                 slot_done;

  bridge_decode i_bridge_decode (
    .clk_74a          (clk_74a),
    .arst_n           (arst_n),
    .bridge_addr      (bridge_addr),
    .bridge_wr        (bridge_wr),
    .bridge_wr_data   (bridge_wr_data),
    .settings         (settings),
    .reset_hold_start (reset_hold_start),
    .load_push        (load_push),
    .load_word        (load_word)
  );

  reset_hold_timer i_reset_hold_timer (
    .clk_74a          (clk_74a),
    .arst_n           (arst_n),
    .reset_hold_start (reset_hold_start),
    .core_reset       (core_reset)
  );

  ////////////////////////////////////////////////////////////
  // cart download path
  ////////////////////////////////////////////////////////////

  load_word_fifo i_load_word_fifo (
    .clk_74a       (clk_74a),
    .arst_n        (arst_n),
    .load_push     (load_push),
    .load_word     (load_word),
    .fifo_pop      (fifo_pop),
    .fifo_empty    (fifo_empty),
    .fifo_word     (fifo_word),
    .load_overflow (load_overflow)
  );

  loader_sequencer i_loader_sequencer (
    .clk_74a    (clk_74a),
    .arst_n     (arst_n),
    .fifo_empty (fifo_empty),
    .fifo_word  (fifo_word),
    .fifo_pop   (fifo_pop),
    .slot_start (slot_start),
    .slot_en    (slot_en),
    .slot_done  (slot_done),
    .load_write (load_write)
  );

  pace_timer i_pace_timer (
    .clk_74a    (clk_74a),
    .arst_n     (arst_n),
    .slot_start (slot_start),
    .slot_en    (slot_en),
    .slot_done  (slot_done)
  );

endmodule

/* core_top_asserts.sv */
////////////////////////////////////////////////////////////
// concurrent checks on download write pacing
// and on the core reset hold, bound into core_top
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module core_top_asserts (
  input logic                   clk_74a,
  input logic                   arst_n,
  input core_pkg::bridge_addr_t bridge_addr,
  input logic                   bridge_wr,
  input logic                   core_reset,
  input core_pkg::mem_write_t   load_write
);

  int en_run;

  // length of the current enable run
  always @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      en_run <= 0;
    end else if (load_write.en) begin
      en_run <= en_run + 1;
    end else begin
      en_run <= 0;
    end
  end

  en_window: assert property (@(posedge clk_74a) disable iff (!arst_n)
    en_run <= core_pkg::WRITE_EN_CYCLES)
    else $error("load_write.en high longer than the enable window");

  write_stable: assert property (@(posedge clk_74a) disable iff (!arst_n)
    (load_write.en && $past(load_write.en)) |->
      ($stable(load_write.addr) && $stable(load_write.data)))
    else $error("load_write addr or data moved while en was high");

  reset_rise: assert property (@(posedge clk_74a) disable iff (!arst_n)
    $rose(core_reset) |-> $past(bridge_wr && (bridge_addr == core_pkg::ADDR_RESET)))
    else $error("core_reset rose without a reset write in the cycle before");

endmodule

bind core_top core_top_asserts i_core_top_asserts (
  .clk_74a     (clk_74a),
  .arst_n      (arst_n),
  .bridge_addr (bridge_addr),
  .bridge_wr   (bridge_wr),
  .core_reset  (core_reset),
  .load_write  (load_write)
);

/* load_word_fifo.sv */
////////////////////////////////////////////////////////////
// first-word-fall-through FIFO of download words
// sticky overflow flag on a push while full
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module load_word_fifo (
  input  logic                 clk_74a,
  input  logic                 arst_n,
  input  logic                 load_push,
  input  core_pkg::load_word_t load_word,
  input  logic                 fifo_pop,
  output logic                 fifo_empty,
  output core_pkg::load_word_t fifo_word,
  output logic                 load_overflow
);

  core_pkg::load_word_t mem [core_pkg::LOAD_FIFO_DEPTH];

  core_pkg::fifo_ptr_t wr_ptr;
  core_pkg::fifo_ptr_t rd_ptr;
  logic                fifo_full;
  logic                do_push;
  logic                do_pop;

  // same index with opposite wrap bits means full
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[core_pkg::FIFO_IDX_W-1:0] == rd_ptr[core_pkg::FIFO_IDX_W-1:0]) &&
                      (wr_ptr[core_pkg::FIFO_IDX_W] != rd_ptr[core_pkg::FIFO_IDX_W]);

  assign do_push = load_push && !fifo_full;
  assign do_pop  = fifo_pop && !fifo_empty;

  // head word always visible
  assign fifo_word = mem[rd_ptr[core_pkg::FIFO_IDX_W-1:0]];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (do_push) begin
      mem[wr_ptr[core_pkg::FIFO_IDX_W-1:0]] <= load_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers and overflow
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      load_overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + core_pkg::fifo_ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + core_pkg::fifo_ptr_t'(1);
      end
      // dropped word stays flagged until reset
      if (load_push && fifo_full) begin
        load_overflow <= 1'b1;
      end
    end
  end

endmodule

/* loader_sequencer.sv */
////////////////////////////////////////////////////////////
// download loader FSM
// pops a word, writes high then low halfword in paced slots
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module loader_sequencer (
  input  logic                 clk_74a,
  input  logic                 arst_n,
  input  logic                 fifo_empty,
  input  core_pkg::load_word_t fifo_word,
  output logic                 fifo_pop,
  output logic                 slot_start,
  input  logic                 slot_en,
  input  logic                 slot_done,
  output core_pkg::mem_write_t load_write
);

  core_pkg::loader_state_t state_q;
  core_pkg::loader_state_t state_d;
  core_pkg::load_word_t    word_q;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    fifo_pop   = 1'b0;
    slot_start = 1'b0;
    case (state_q)
      core_pkg::LOAD_IDLE: begin
        if (!fifo_empty) begin
          fifo_pop   = 1'b1;
          slot_start = 1'b1;
          state_d    = core_pkg::LOAD_HI;
        end
      end
      core_pkg::LOAD_HI: begin
        if (slot_done) begin
          slot_start = 1'b1;
          state_d    = core_pkg::LOAD_LO;
        end
      end
      core_pkg::LOAD_LO: begin
        // go straight to the next word when one is queued
        if (slot_done) begin
          if (!fifo_empty) begin
            fifo_pop   = 1'b1;
            slot_start = 1'b1;
            state_d    = core_pkg::LOAD_HI;
          end else begin
            state_d = core_pkg::LOAD_IDLE;
          end
        end
      end
      default: begin
        state_d = core_pkg::LOAD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= core_pkg::LOAD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // current word held for both slots
  always_ff @(posedge clk_74a) begin
    if (fifo_pop) begin
      word_q <= fifo_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory write
  ////////////////////////////////////////////////////////////

  // big-endian order puts the high halfword at addr and the low one at addr + 2
  always_comb begin
    load_write.en = slot_en && (state_q != core_pkg::LOAD_IDLE);
    if (state_q == core_pkg::LOAD_LO) begin
      load_write.addr = word_q.addr + core_pkg::mem_addr_t'(2);
      load_write.data = word_q.data[15:0];
    end else begin
      load_write.addr = word_q.addr;
      load_write.data = word_q.data[31:16];
    end
  end

endmodule

/* pace_timer.sv */
////////////////////////////////////////////////////////////
// halfword write slot timer
// enable window at slot start, done pulse on the last cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pace_timer (
  input  logic clk_74a,
  input  logic arst_n,
  input  logic slot_start,
  output logic slot_en,
  output logic slot_done
);

  core_pkg::slot_cnt_t cnt;
  logic                active;

  assign slot_en   = active && (cnt < core_pkg::SLOT_EN_END);
  assign slot_done = active && (cnt == core_pkg::SLOT_LAST);

  // a start in the done cycle chains the next slot without a gap
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      cnt    <= '0;
      active <= 1'b0;
    end else if (slot_start) begin
      cnt    <= '0;
      active <= 1'b1;
    end else if (active) begin
      if (cnt == core_pkg::SLOT_LAST) begin
        active <= 1'b0;
        cnt    <= '0;
      end else begin
        cnt <= cnt + core_pkg::slot_cnt_t'(1);
      end
    end
  end

endmodule

/* reset_hold_timer.sv */
////////////////////////////////////////////////////////////
// core reset hold counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module reset_hold_timer (
  input  logic clk_74a,
  input  logic arst_n,
  input  logic reset_hold_start,
  output logic core_reset
);

  core_pkg::hold_cnt_t count;

  // a new request reloads the count, so a second write extends the hold
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      count      <= '0;
      core_reset <= 1'b0;
    end else if (reset_hold_start) begin
      count      <= core_pkg::hold_cnt_t'(core_pkg::RESET_HOLD_CYCLES);
      core_reset <= 1'b1;
    end else if (count != '0) begin
      count      <= count - core_pkg::hold_cnt_t'(1);
      // drops together with the last count
      core_reset <= (count > core_pkg::hold_cnt_t'(1));
    end else begin
      core_reset <= 1'b0;
    end
  end

endmodule

/* tb_core_top.sv */
////////////////////////////////////////////////////////////
// testbench for the bridge control top level
// stimulus table, reference model, write monitor,
// compare tasks, cycle timeout and closing summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_core_top;

  typedef enum logic [1:0] {
    KIND_SET,
    KIND_RST,
    KIND_LOAD
  } entry_kind_t;

  // one bridge write, idle cycles after it, overflow level expected after it
  typedef struct packed {
    core_pkg::bridge_addr_t addr;
    core_pkg::bridge_data_t data;
    int                     idle;
    entry_kind_t            kind;
    logic                   exp_ovf;
  } stim_entry_t;

  localparam int WORD_CYCLES = 2 * core_pkg::WRITE_SLOT_CYCLES;

  logic                     clk_74a = 1'b0;
  logic                     arst_n;
  core_pkg::bridge_addr_t   bridge_addr;
  logic                     bridge_wr;
  core_pkg::bridge_data_t   bridge_wr_data;
  core_pkg::core_settings_t settings;
  logic                     core_reset;
  core_pkg::mem_write_t     load_write;
  logic                     load_overflow;

  stim_entry_t              stim_q[$];
  core_pkg::mem_write_t     exp_wr_q[$];
  int                       exp_rise_q[$];
  int                       pop_edge_q[$];
  core_pkg::core_settings_t exp_settings;
  int                       cyc = 0;
  int                       limit = 0;
  int                       reset_start;
  int                       reset_end;
  int                       next_free;
  int                       en_len;
  logic                     en_prev;
  logic                     run_checks = 1'b0;
  int                       mismatch_count;
  int                       error_count;

  core_pkg::bridge_addr_t set_addrs [10] = '{
    core_pkg::ADDR_TURBO_TAP, core_pkg::ADDR_BUTTON6, core_pkg::ADDR_BTN1_SPEED,
    core_pkg::ADDR_BTN2_SPEED, core_pkg::ADDR_OVERSCAN, core_pkg::ADDR_EXTRA_SPRITES,
    core_pkg::ADDR_RAW_RGB, core_pkg::ADDR_MASTER_BOOST, core_pkg::ADDR_ADPCM_BOOST,
    core_pkg::ADDR_CD_BOOST
  };

  core_top i_core_top (
    .clk_74a        (clk_74a),
    .arst_n         (arst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .core_reset     (core_reset),
    .load_write     (load_write),
    .load_overflow  (load_overflow)
  );

  always #4 clk_74a = ~clk_74a;

  always @(posedge clk_74a) begin
    cyc <= cyc + 1;
  end

  always @(posedge clk_74a) begin
    if (limit > 0 && cyc >= limit) begin
      $display("ERROR: timeout after %0d cycles, the run did not finish", cyc);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_settings(core_pkg::core_settings_t got, core_pkg::core_settings_t exp,
                                string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_write(core_pkg::mem_write_t got, core_pkg::mem_write_t exp, string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got addr %h data %h expected addr %h data %h",
               $time, what, got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic core_pkg::core_settings_t model_setting(core_pkg::core_settings_t cur,
      core_pkg::bridge_addr_t addr, core_pkg::bridge_data_t data);
    core_pkg::core_settings_t s;
    s = cur;
    case (addr)
      core_pkg::ADDR_TURBO_TAP:     s.turbo_tap_enable     = data[0];
      core_pkg::ADDR_BUTTON6:       s.button6_enable       = data[0];
      core_pkg::ADDR_BTN1_SPEED:    s.button1_turbo_speed  = data[1:0];
      core_pkg::ADDR_BTN2_SPEED:    s.button2_turbo_speed  = data[1:0];
      core_pkg::ADDR_OVERSCAN:      s.overscan_enable      = data[0];
      core_pkg::ADDR_EXTRA_SPRITES: s.extra_sprites_enable = data[0];
      core_pkg::ADDR_RAW_RGB:       s.raw_rgb_enable       = data[0];
      core_pkg::ADDR_MASTER_BOOST:  s.master_audio_boost   = data[1:0];
      core_pkg::ADDR_ADPCM_BOOST:   s.adpcm_audio_boost    = data[0];
      core_pkg::ADDR_CD_BOOST:      s.cd_audio_boost       = data[0];
      default:                      s = cur;
    endcase
    return s;
  endfunction

  // word lands in the FIFO two edges after the drive and pops once the loader is free
  task automatic model_load(core_pkg::bridge_addr_t addr, core_pkg::bridge_data_t data);
    int                   push_edge;
    int                   pop_edge;
    int                   held;
    core_pkg::mem_write_t wr;
    push_edge = cyc + 2;
    held = 0;
    foreach (pop_edge_q[k]) begin
      if (pop_edge_q[k] >= push_edge) begin
        held++;
      end
    end
    // full FIFO drops the word
    if (held < core_pkg::LOAD_FIFO_DEPTH) begin
      pop_edge = (push_edge + 1 > next_free) ? push_edge + 1 : next_free;
      next_free = pop_edge + WORD_CYCLES;
      pop_edge_q.push_back(pop_edge);
      wr.en   = 1'b1;
      wr.addr = addr[23:0];
      wr.data = data[31:16];
      exp_wr_q.push_back(wr);
      exp_rise_q.push_back(pop_edge);
      wr.addr = addr[23:0] + 24'd2;
      wr.data = data[15:0];
      exp_wr_q.push_back(wr);
      exp_rise_q.push_back(pop_edge + core_pkg::WRITE_SLOT_CYCLES);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_entry(core_pkg::bridge_addr_t a, core_pkg::bridge_data_t d, int idle,
                           entry_kind_t k, logic ovf);
    stim_q.push_back('{a, d, idle, k, ovf});
  endtask

  function automatic core_pkg::bridge_addr_t load_addr();
    return {core_pkg::LOAD_REGION, 28'($urandom()) & 28'hFFF_FFFC};
  endfunction

  task automatic build_table();
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 10; i++) begin
        add_entry(set_addrs[i], $urandom(), 2, KIND_SET, 1'b0);
      end
    end
    // unmapped addresses must change nothing
    add_entry(32'h0000_0110, 32'hFFFF_FFFF, 2, KIND_SET, 1'b0);
    add_entry(32'h0000_0054, 32'hFFFF_FFFF, 2, KIND_SET, 1'b0);
    add_entry(32'h2000_0100, 32'hFFFF_FFFF, 2, KIND_SET, 1'b0);
    // second reset write lands inside the first hold
    add_entry(core_pkg::ADDR_RESET, $urandom(), 100, KIND_RST, 1'b0);
    add_entry(core_pkg::ADDR_RESET, $urandom(), 300, KIND_RST, 1'b0);
    add_entry(load_addr(), $urandom(), 40, KIND_LOAD, 1'b0);
    for (int k = 0; k < 6; k++) begin
      add_entry(load_addr(), $urandom(), (k == 5) ? 202 : 0, KIND_LOAD, 1'b0);
    end
    for (int k = 0; k < 12; k++) begin
      add_entry(load_addr(), $urandom(), (k == 11) ? 298 : 0, KIND_LOAD, k == 11);
    end
  endtask

  task automatic apply_entry(stim_entry_t e);
    @(posedge clk_74a);
    #1;
    bridge_addr    = e.addr;
    bridge_wr      = 1'b1;
    bridge_wr_data = e.data;
    case (e.kind)
      KIND_SET: exp_settings = model_setting(exp_settings, e.addr, e.data);
      KIND_RST: begin
        if (reset_end < cyc) begin
          reset_start = cyc + 1;
        end
        reset_end = cyc + core_pkg::RESET_HOLD_CYCLES;
      end
      default: model_load(e.addr, e.data);
    endcase
    if (e.idle >= 1) begin
      @(posedge clk_74a);
      #1;
      bridge_wr = 1'b0;
      // a setting takes its value one cycle after the write
      check_settings(settings, exp_settings, "settings");
      repeat (e.idle - 1) begin
        @(posedge clk_74a);
        #1;
      end
      check_bit(load_overflow, e.exp_ovf, "load_overflow");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitor sampling at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_74a) begin
    if (run_checks) begin
      check_bit(core_reset, (cyc >= reset_start) && (cyc <= reset_end), "core_reset");
      if (load_write.en && !en_prev) begin
        en_len = 0;
        if (exp_wr_q.size() == 0) begin
          error_count++;
          $display("ERROR: a memory write started at %0t but none was expected", $time);
        end else begin
          check_write(load_write, exp_wr_q.pop_front(), "load_write");
          check_count(cyc, exp_rise_q.pop_front(), "enable rise cycle");
        end
      end
      if (load_write.en) begin
        en_len++;
      end else if (en_prev) begin
        check_count(en_len, core_pkg::WRITE_EN_CYCLES, "enable length");
      end
      en_prev = load_write.en;
    end
  end

  initial begin
    void'($urandom(10));
    arst_n         = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    exp_settings   = '0;
    reset_start    = 0;
    reset_end      = -1;
    next_free      = 0;
    en_len         = 0;
    en_prev        = 1'b0;
    mismatch_count = 0;
    error_count    = 0;
    build_table();
    limit = stim_q.size() * 40 + core_pkg::RESET_HOLD_CYCLES + 200;
    repeat (8) @(posedge clk_74a);
    #1;
    arst_n = 1'b1;
    // idle state after reset
    check_settings(settings, '0, "settings after reset");
    check_bit(core_reset, 1'b0, "core_reset after reset");
    check_bit(load_write.en, 1'b0, "load_write.en after reset");
    check_bit(load_overflow, 1'b0, "load_overflow after reset");
    run_checks = 1'b1;
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
    end
    repeat (4) @(posedge clk_74a);
    if (exp_wr_q.size() != 0) begin
      error_count++;
      $display("ERROR: %0d expected halfword writes never came out", exp_wr_q.size());
    end
    $display("summary: %0d entries, %0d mismatches, %0d other errors",
             stim_q.size(), mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
